// File: sources.f
+incdir+include
logic/spritePkg.sv
logic/lineBuffer.sv
logic/spriteScanner.sv
logic/spriteRenderer.sv
logic/spriteEngine.sv
test/clockGen.sv
test/spriteEngineTb.sv

// File: runSim.sh
#!/bin/bash
# Verilator build and run of the sprite engine testbench

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module spriteEngineTb -f sources.f -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: test/spriteEngineTb.sv
// Sprite engine testbench
`timescale 1ns/1ps
`include "spriteEngine_defs.svh"

module spriteEngineTb;

	localparam int NumLines = 66;
	localparam int LineLen  = 320;

	logic        VCLKx8;
	logic        rstN;
	logic        pxEn;
	logic [8:0]  hPos;
	logic [8:0]  vPos;
	logic [9:0]  sprAddr;
	logic [15:0] sprData = '0;
	logic [17:0] romAddr;
	logic [7:0]  romData;
	spritePkg::sprPixel_t sprPixel;
	logic        sprColl;
	logic [9:0]  collAddr;

	logic [15:0] sprMem [0:1023];
	logic [7:0]  romMem [0:262143];
	logic [10:0] expLine [0:3][0:255];
	logic [9:0]  collQ [$];
	logic [2:0]  tick;
	integer      seed;
	int          valueErrors;
	int          otherErrors;
	int          pixelChecks;
	int          collChecks;
	int          prevH;
	int          prevV;
	int          sampH;
	int          sampV;
	bit          prevValid;
	bit          doCheck;

	clockGen u_clockGen (
		.VCLKx8 (VCLKx8),
		.rstN   (rstN)
	);

	spriteEngine u_spriteEngine (
		.VCLKx8   (VCLKx8),
		.rstN     (rstN),
		.pxEn     (pxEn),
		.hPos     (hPos),
		.vPos     (vPos),
		.sprAddr  (sprAddr),
		.sprData  (sprData),
		.romAddr  (romAddr),
		.romData  (romData),
		.sprPixel (sprPixel),
		.sprColl  (sprColl),
		.collAddr (collAddr)
	);

	// sprite RAM has one clock of latency and ROM none
	always @(posedge VCLKx8) begin
		sprData <= sprMem[sprAddr];
	end
	assign romData = romMem[romAddr];

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			valueErrors++;
			$display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic int randBelow(input int n);
		randBelow = ($random(seed) & 32'h7fffffff) % n;
	endfunction

	// all entries unused with filler in the other words
	task automatic clearTable();
		for (int a = 0; a < 1024; a++) begin
			sprMem[a] = (a % 8 == 0) ? 16'h00FF : (16'(a) * 16'h0123) ^ 16'h5a5a;
		end
	endtask

	task automatic placeSprite(input int num, input int top, input int height, input int xScr,
		input logic [2:0] bank, input logic [15:0] stride, input logic [15:0] base);
		logic [9:0] raw;
		raw = 10'(2 * (xScr - `SPR_XOFS));
		sprMem[num * 8]     = {8'(top + height), 8'(top)};
		sprMem[num * 8 + 1] = {bank[0], bank[1], bank[2], 3'b000, raw};
		sprMem[num * 8 + 2] = stride;
		sprMem[num * 8 + 3] = base;
	endtask

	// bytes listed first to last in fetch order
	task automatic storeRow(input logic [17:0] start, input bit down, input logic [31:0] bytes,
		input int n);
		for (int j = 0; j < n; j++) begin
			romMem[down ? start - 18'(j) : start + 18'(j)] = bytes[8 * (n - 1 - j) +: 8];
		end
	endtask

	task automatic loadScenario(input int v);
		int s;
		int n;
		int h;
		int w;
		logic [15:0] base;
		s = (v + 1) / 8;
		if ((v + 1) % 8 == 0) begin
			clearTable();
			case (s)
				// single sprite with transparent pixels and early row ends
				1: begin
					placeSprite(3, 9, 4, 40, 3'b000, 16'h0008, 16'h0100);
					storeRow(18'h00108, 0, 32'h120345FF, 4);
					storeRow(18'h00110, 0, 32'h6F000000, 4);
					storeRow(18'h00118, 0, 32'h7008BF00, 4);
					storeRow(18'h00120, 0, 32'hA1FF0000, 4);
				end
				// mirrored sprite in ROM bank 1
				2: begin
					placeSprite(7, 17, 3, 100, 3'b001, 16'h0010, 16'h8200);
					storeRow(18'h08210, 1, 32'h002143F5, 3);
					storeRow(18'h08220, 1, 32'h0087F600, 3);
					storeRow(18'h08230, 1, 32'h0C000FFF, 3);
				end
				// two overlapping sprites
				3: begin
					placeSprite(2, 25, 3, 60, 3'b000, 16'h0004, 16'h0400);
					placeSprite(9, 26, 4, 62, 3'b000, 16'h0004, 16'h0500);
					for (int r = 1; r <= 4; r++) begin
						storeRow(18'h00400 + 18'(4 * r), 0, 32'h111111FF, 4);
						storeRow(18'h00500 + 18'(4 * r), 0, 32'h202022FF, 4);
					end
				end
				5, 6, 7: begin
					n = 1 + randBelow(6);
					for (int k = 0; k < n; k++) begin
						h = 1 + randBelow(3);
						base = 16'h2000 + 16'(k * 16'h40);
						placeSprite(randBelow(32), 8 * s + randBelow(6), h, 16 + randBelow(200),
							3'b000, 16'h0004, base);
						for (int r = 1; r <= h; r++) begin
							w = 1 + randBelow(3);
							for (int j = 0; j < w; j++) begin
								romMem[18'(base) + 18'(4 * r + j)] = {4'(randBelow(15)),
									4'(randBelow(15))};
							end
							romMem[18'(base) + 18'(4 * r + w)] = 8'hFF;
						end
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	// expected line buffer and collisions for one target line
	function automatic void renderLine(input logic [7:0] target, input int slot);
		spritePkg::sprPixel_t lineBuf [0:511];
		logic [15:0] w0;
		logic [15:0] w1;
		logic [15:0] addr;
		logic [2:0]  bank;
		logic [8:0]  x;
		logic [7:0]  row;
		logic [7:0]  b;
		logic [3:0]  c [0:1];
		bit          flip;
		bit          stop;
		for (int i = 0; i < 512; i++) begin
			lineBuf[i] = '0;
		end
		for (int i = 0; i < `SPR_COUNT; i++) begin
			w0 = sprMem[i * 8];
			if (w0[7:0] != 8'hFF && target >= w0[7:0] && target < w0[15:8]) begin
				row  = target - w0[7:0] + 8'd1;
				w1   = sprMem[i * 8 + 1];
				x    = 9'(w1[9:1]) + 9'(`SPR_XOFS);
				bank = {w1[13], w1[14], w1[15]};
				addr = sprMem[i * 8 + 3] + sprMem[i * 8 + 2] * 16'(row);
				flip = addr[15];
				stop = 0;
				for (int n = 0; n < 64 && !stop; n++) begin
					b    = romMem[{bank, addr[14:0]}];
					addr = flip ? addr - 16'd1 : addr + 16'd1;
					c[0] = flip ? b[3:0] : b[7:4];
					c[1] = flip ? b[7:4] : b[3:0];
					for (int p = 0; p < 2 && !stop; p++) begin
						if (c[p] == 4'hF) begin
							stop = 1;
						end else begin
							if (c[p] != 4'h0) begin
								if (lineBuf[x].color != 4'h0) begin
									collQ.push_back({5'(i), lineBuf[x].num});
								end
								lineBuf[x] = '{pal: 2'b00, num: 5'(i), color: c[p]};
							end
							x = x + 9'd1;
						end
					end
				end
			end
		end
		for (int i = 0; i < 256; i++) begin
			expLine[slot][i] = lineBuf[i];
		end
	endfunction

	// display line L shows target line L-1
	always begin
		@(posedge VCLKx8);
		if (rstN && pxEn) begin
			sampH = prevH;
			sampV = prevV;
			doCheck = prevValid && prevH < 256 && prevV >= 2;
			prevH = hPos;
			prevV = vPos;
			prevValid = 1;
			if (doCheck) begin
				@(negedge VCLKx8);
				pixelChecks++;
				checkValue("sprPixel", 32'(sprPixel), 32'(expLine[(sampV - 1) % 4][sampH]));
			end
		end
	end

	always @(negedge VCLKx8) begin
		if (rstN && sprColl) begin
			if (collQ.size() == 0) begin
				otherErrors++;
				$display("unexpected collision pulse with address %h at %0t", collAddr, $time);
			end else begin
				collChecks++;
				checkValue("collAddr", 32'(collAddr), 32'(collQ.pop_front()));
			end
		end
	end

	initial begin
		#((NumLines + 2) * LineLen * 8 * 8);
		$display("watchdog expired before the last line was drawn");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		pxEn = 1'b0;
		hPos = '0;
		vPos = '0;
		tick = '0;
		seed = 12;
		for (int a = 0; a < 262144; a++) begin
			romMem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
		end
		clearTable();
		for (int s = 0; s < 4; s++) begin
			for (int i = 0; i < 256; i++) begin
				expLine[s][i] = '0;
			end
		end
		wait (rstN);
		while (vPos < NumLines) begin
			@(posedge VCLKx8);
			tick <= tick + 3'd1;
			pxEn <= (tick == 3'd6);
			if (tick == 3'd7) begin
				if (hPos == LineLen - 1) begin
					hPos <= '0;
					vPos <= vPos + 9'd1;
				end else begin
					hPos <= hPos + 9'd1;
				end
				// new table goes in as blanking starts and before the scan
				if (hPos == 9'd255) begin
					@(negedge VCLKx8);
					loadScenario(vPos);
					renderLine(vPos[7:0] + 8'd1, (vPos + 1) % 4);
				end
			end
		end
		@(negedge VCLKx8);
		if (collQ.size() != 0) begin
			otherErrors++;
			$display("%0d expected collisions never pulsed", collQ.size());
		end
		$display("pixels checked %0d, collisions checked %0d, value errors %0d, other errors %0d",
			pixelChecks, collChecks, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: test/clockGen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module clockGen (
	output logic VCLKx8,
	output logic rstN
);

	initial begin
		VCLKx8 = 1'b0;
		forever #4 VCLKx8 = ~VCLKx8;
	end

	// reset held low for four clocks
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge VCLKx8);
		rstN <= 1'b1;
	end

endmodule

// File: logic/spriteEngine.sv
// Sprite engine top level
`timescale 1ns/1ps
`include "spriteEngine_defs.svh"

module spriteEngine (
	input  logic                 VCLKx8,
	input  logic                 rstN,
	input  logic                 pxEn,
	input  logic [8:0]           hPos,
	input  logic [8:0]           vPos,
	output logic [9:0]           sprAddr,
	input  logic [15:0]          sprData,
	output logic [17:0]          romAddr,
	input  logic [7:0]           romData,
	output spritePkg::sprPixel_t sprPixel,
	output logic                 sprColl,
	output logic [9:0]           collAddr
);

	logic [9:0] scanAddr;
	logic [9:0] rendAddr;
	logic [5:0] hitNum [0:`SPR_COUNT-1];
	logic [7:0] hitRow [0:`SPR_COUNT-1];
	logic [5:0] hitCount;

	logic [9:0]           rdAddr;
	logic [9:0]           rdAddrDly;
	logic                 rdClear;
	spritePkg::sprPixel_t rdPixel;
	logic [9:0]           wrAddr;
	spritePkg::sprPixel_t wrData;
	logic                 wrEn;
	spritePkg::sprPixel_t oldPixel;

	// scanner owns sprite RAM during blanking
	assign sprAddr = hPos[8] ? scanAddr : rendAddr;

	// from the second clock on a given address the entry is wiped
	assign rdClear = (rdAddr == rdAddrDly);

	always_ff @(posedge VCLKx8) begin
		if (!rstN) begin
			rdAddr    <= '0;
			// differs from rdAddr so the first entry gets loaded
			rdAddrDly <= '1;
			sprPixel  <= '0;
		end else begin
			rdAddrDly <= rdAddr;
			if (pxEn) begin
				sprPixel <= rdPixel;
				rdAddr   <= {vPos[0], hPos};
			end
		end
	end

	spriteScanner u_spriteScanner (
		.VCLKx8   (VCLKx8),
		.rstN     (rstN),
		.hPos     (hPos),
		.vPos     (vPos),
		.scanAddr (scanAddr),
		.sprData  (sprData),
		.hitNum   (hitNum),
		.hitRow   (hitRow),
		.hitCount (hitCount)
	);

	spriteRenderer u_spriteRenderer (
		.VCLKx8   (VCLKx8),
		.rstN     (rstN),
		.hPos     (hPos),
		.vPos     (vPos),
		.rendAddr (rendAddr),
		.sprData  (sprData),
		.hitNum   (hitNum),
		.hitRow   (hitRow),
		.hitCount (hitCount),
		.romAddr  (romAddr),
		.romData  (romData),
		.wrAddr   (wrAddr),
		.wrData   (wrData),
		.wrEn     (wrEn),
		.oldPixel (oldPixel),
		.sprColl  (sprColl),
		.collAddr (collAddr)
	);

	lineBuffer u_lineBuffer (
		.VCLKx8   (VCLKx8),
		.rdAddr   (rdAddr),
		.rdClear  (rdClear),
		.rdPixel  (rdPixel),
		.wrAddr   (wrAddr),
		.wrData   (wrData),
		.wrEn     (wrEn),
		.oldPixel (oldPixel)
	);

endmodule

// File: logic/spriteRenderer.sv
// Display-time sprite renderer
`timescale 1ns/1ps
`include "spriteEngine_defs.svh"

module spriteRenderer (
	input  logic                 VCLKx8,
	input  logic                 rstN,
	input  logic [8:0]           hPos,
	input  logic [8:0]           vPos,
	output logic [9:0]           rendAddr,
	input  logic [15:0]          sprData,
	input  logic [5:0]           hitNum [0:`SPR_COUNT-1],
	input  logic [7:0]           hitRow [0:`SPR_COUNT-1],
	input  logic [5:0]           hitCount,
	output logic [17:0]          romAddr,
	input  logic [7:0]           romData,
	output logic [9:0]           wrAddr,
	output spritePkg::sprPixel_t wrData,
	output logic                 wrEn,
	input  spritePkg::sprPixel_t oldPixel,
	output logic                 sprColl,
	output logic [9:0]           collAddr
);

	spritePkg::renderPhase_t phase;

	logic [5:0]  hitIdx;
	logic [5:0]  sprNum;
	logic [2:0]  wordOfs;
	logic [7:0]  rowOfs;
	logic [8:0]  xPos;
	logic [2:0]  bank;
	logic [15:0] stride;
	logic [15:0] srcAddr;
	logic        hFlip;
	logic        wrBank;
	logic [3:0]  waitCnt;
	logic [7:0]  romByte;
	logic [10:0] xHalf;
	logic [15:0] rowAddr;
	logic [3:0]  col0;
	logic [3:0]  col1;
	logic        wordEnd;

	assign rendAddr = {1'b0, sprNum, wordOfs};
	assign romAddr  = {bank, srcAddr[14:0]};
	assign wrAddr   = {wrBank, xPos};

	// x is stored at double resolution
	assign xHalf   = (11'(sprData[9:0]) + 11'd1) >> 1;
	assign rowAddr = sprData + stride * 16'(rowOfs);

	// mirrored rows take the low nibble first
	assign col0 = hFlip ? romByte[3:0] : romByte[7:4];
	assign col1 = hFlip ? romByte[7:4] : romByte[3:0];

	// last byte of a 16-bit word in the current direction
	assign wordEnd = hFlip ? ~srcAddr[0] : srcAddr[0];

	always_ff @(posedge VCLKx8) begin
		if (!rstN) begin
			phase   <= spritePkg::phIdle;
			hitIdx  <= '0;
			wrEn    <= 1'b0;
			sprColl <= 1'b0;
		end else begin
			wrEn    <= 1'b0;
			sprColl <= 1'b0;
			if (hPos[8]) begin
				phase <= spritePkg::phIdle;
			end else begin
				case (phase)
					spritePkg::phIdle: begin
						hitIdx <= '0;
						wrBank <= ~vPos[0];
						phase  <= (hitCount != 6'd0) ? spritePkg::phSelect : spritePkg::phDone;
					end
					spritePkg::phSelect: begin
						sprNum  <= hitNum[hitIdx[4:0]];
						rowOfs  <= hitRow[hitIdx[4:0]];
						wordOfs <= 3'd1;
						phase   <= spritePkg::phRequest;
					end
					// sprite RAM answers one clock after the address
					spritePkg::phRequest: begin
						wordOfs <= 3'd2;
						phase   <= spritePkg::phXPos;
					end
					spritePkg::phXPos: begin
						xPos    <= xHalf[8:0] + 9'(`SPR_XOFS);
						bank    <= {sprData[13], sprData[14], sprData[15]};
						wordOfs <= 3'd3;
						phase   <= spritePkg::phStride;
					end
					spritePkg::phStride: begin
						stride <= sprData;
						phase  <= spritePkg::phAddr;
					end
					spritePkg::phAddr: begin
						srcAddr <= rowAddr;
						hFlip   <= rowAddr[15];
						waitCnt <= 4'(`SPR_FIRSTWAIT);
						phase   <= spritePkg::phFetch;
					end
					spritePkg::phFetch: begin
						if (waitCnt == 4'd0) begin
							romByte <= romData;
							srcAddr <= hFlip ? (srcAddr - 16'd1) : (srcAddr + 16'd1);
							// next byte sits in a new word
							if (wordEnd) begin
								waitCnt <= 4'(`SPR_WORDWAIT);
							end
							phase <= spritePkg::phPix0;
						end else begin
							waitCnt <= waitCnt - 4'd1;
						end
					end
					spritePkg::phPix0: begin
						if (col0 != `SPR_ENDROW) begin
							wrData <= '{pal: '0, num: sprNum[4:0], color: col0};
							wrEn   <= 1'b1;
							phase  <= spritePkg::phColl0;
						end else begin
							phase <= spritePkg::phNext;
						end
					end
					spritePkg::phColl0: begin
						// oldPixel holds the entry from before this write
						if ((col0 != `SPR_TRANSP) && (oldPixel.color != `SPR_TRANSP)) begin
							sprColl  <= 1'b1;
							collAddr <= {sprNum[4:0], oldPixel.num};
						end
						xPos  <= xPos + 9'd1;
						phase <= spritePkg::phPix1;
					end
					spritePkg::phPix1: begin
						if (col1 != `SPR_ENDROW) begin
							wrData <= '{pal: '0, num: sprNum[4:0], color: col1};
							wrEn   <= 1'b1;
							phase  <= spritePkg::phColl1;
						end else begin
							phase <= spritePkg::phNext;
						end
					end
					spritePkg::phColl1: begin
						if ((col1 != `SPR_TRANSP) && (oldPixel.color != `SPR_TRANSP)) begin
							sprColl  <= 1'b1;
							collAddr <= {sprNum[4:0], oldPixel.num};
						end
						xPos  <= xPos + 9'd1;
						phase <= spritePkg::phFetch;
					end
					spritePkg::phNext: begin
						hitIdx <= hitIdx + 6'd1;
						phase  <= ((hitIdx + 6'd1) == hitCount) ? spritePkg::phDone
							: spritePkg::phSelect;
					end
					spritePkg::phDone: begin
						phase <= spritePkg::phDone;
					end
					default: begin
						phase <= spritePkg::phIdle;
					end
				endcase
			end
		end
	end

	// rendering has to finish inside the display period
	noBlankWrite: assert property (@(posedge VCLKx8) disable iff (!rstN)
		hPos[8] |-> !wrEn);

endmodule

// File: logic/spriteScanner.sv
// Blanking-time sprite hit scan
`timescale 1ns/1ps
`include "spriteEngine_defs.svh"

module spriteScanner (
	input  logic        VCLKx8,
	input  logic        rstN,
	input  logic [8:0]  hPos,
	input  logic [8:0]  vPos,
	output logic [9:0]  scanAddr,
	input  logic [15:0] sprData,
	output logic [5:0]  hitNum [0:`SPR_COUNT-1],
	output logic [7:0]  hitRow [0:`SPR_COUNT-1],
	output logic [5:0]  hitCount
);

	// entry on the address bus
	logic [5:0] scanNum;
	// entry whose word 0 is on sprData this clock
	logic [5:0] testNum;
	logic       testValid;
	// the line after the one being displayed
	logic [7:0] nextLine;
	logic [7:0] sprTop;
	logic [7:0] sprBottom;
	logic       inSpan;

	assign sprTop    = sprData[7:0];
	assign sprBottom = sprData[15:8];
	assign scanAddr  = {2'b00, scanNum[4:0], 3'b000};

	// a top of FF marks an unused entry
	assign inSpan = testValid && (sprTop != 8'hFF) &&
		(nextLine >= sprTop) && (nextLine < sprBottom);

	always_ff @(posedge VCLKx8) begin
		if (!rstN) begin
			scanNum   <= '0;
			testValid <= 1'b0;
			hitCount  <= '0;
		end else if (!hPos[8]) begin
			// display rewinds the walk but the list stays for the renderer
			scanNum   <= '0;
			testValid <= 1'b0;
		end else begin
			if (scanNum == 6'd0) begin
				hitCount <= '0;
			end else if (inSpan) begin
				hitCount <= hitCount + 6'd1;
			end
			testValid <= (scanNum < 6'(`SPR_COUNT));
			if (scanNum < 6'(`SPR_COUNT)) begin
				scanNum <= scanNum + 6'd1;
			end
		end
	end

	always_ff @(posedge VCLKx8) begin
		testNum <= scanNum;
		// latch the target line on the first blanking clock
		if (hPos[8] && (scanNum == 6'd0)) begin
			nextLine <= vPos[7:0] + 8'd1;
		end
		// row offset counts from 1 at the sprite's top line
		if (inSpan) begin
			hitNum[hitCount[4:0]] <= testNum;
			hitRow[hitCount[4:0]] <= nextLine - sprTop + 8'd1;
		end
	end

	countLimit: assert property (@(posedge VCLKx8) disable iff (!rstN)
		hitCount <= 6'(`SPR_COUNT));

endmodule

// File: logic/lineBuffer.sv
// Two-bank sprite line buffer
`timescale 1ns/1ps
`include "spriteEngine_defs.svh"

module lineBuffer (
	input  logic                 VCLKx8,
	input  logic [9:0]           rdAddr,
	input  logic                 rdClear,
	output spritePkg::sprPixel_t rdPixel,
	input  logic [9:0]           wrAddr,
	input  spritePkg::sprPixel_t wrData,
	input  logic                 wrEn,
	output spritePkg::sprPixel_t oldPixel
);

	// bit 9 of either address picks the bank, bits 8:0 are x
	spritePkg::sprPixel_t mem [0:1023];
	logic                 wrKeep;

	// transparent pixels never reach the array
	assign wrKeep = wrEn && (wrData.color != `SPR_TRANSP);

	always_ff @(posedge VCLKx8) begin
		// display side
		// first clock loads the entry, later clocks wipe it and hold the output
		if (rdClear) begin
			mem[rdAddr] <= '0;
		end else begin
			rdPixel <= mem[rdAddr];
		end

		// render side returns the entry as it was before this write
		oldPixel <= mem[wrAddr];
		if (wrKeep) begin
			mem[wrAddr] <= wrData;
		end
	end

	// display and renderer must sit in opposite banks whenever a write is issued
	bankSplit: assert property (@(posedge VCLKx8)
		wrEn |-> (rdAddr[9] != wrAddr[9]));

endmodule

// File: logic/spritePkg.sv
// Sprite engine types
`include "spriteEngine_defs.svh"

package spritePkg;

	// one line buffer entry, palette bank is always zero here
	typedef struct packed {
		logic [`SPR_PALW-1:0]   pal;
		logic [`SPR_NUMW-1:0]   num;
		logic [`SPR_COLORW-1:0] color;
	} sprPixel_t;

	// renderer phases, three attribute reads then two pixels per ROM byte
	typedef enum logic [3:0] {
		phIdle,
		phSelect,
		phRequest,
		phXPos,
		phStride,
		phAddr,
		phFetch,
		phPix0,
		phColl0,
		phPix1,
		phColl1,
		phNext,
		phDone
	} renderPhase_t;

endpackage

// File: include/spriteEngine_defs.svh
// Sprite engine constants
`ifndef SPRITE_ENGINE_DEFS_SVH
`define SPRITE_ENGINE_DEFS_SVH

// entries in the sprite attribute table
`define SPR_COUNT 32

// screen offset added once x has been halved
`define SPR_XOFS 14

// ROM wait before the first byte of a row, and on each 16-bit word crossing
`define SPR_FIRSTWAIT 8
`define SPR_WORDWAIT 6

// line buffer pixel fields
`define SPR_PALW 2
`define SPR_NUMW 5
`define SPR_COLORW 4

// special color codes
`define SPR_TRANSP 4'h0
`define SPR_ENDROW 4'hF

`endif
